//--- hw/tile_io_defines.svh
`ifndef TILE_IO_DEFINES_SVH
`define TILE_IO_DEFINES_SVH

// Stream widths
`define TILE_ADDR_W 32
`define TILE_DATA_W 64
`define TILE_DID_W 8

// Everything from here up is DRAM
`define TILE_DRAM_BASE 32'h8000_0000

// Device field of a local address
`define TILE_DEV_LSB 20
`define TILE_DEV_W 4
`define TILE_DEV_CLINT 4'd1
`define TILE_DEV_CFG 4'd2
`define TILE_DEV_CACHE 4'd3

// Register offsets within a device
`define TILE_OFS_W 16
`define TILE_CFG_FREEZE 16'h0000
`define TILE_CFG_DID 16'h0008
`define TILE_CFG_HOST_DID 16'h0010
`define TILE_CLINT_MSIP 16'h0000
`define TILE_CLINT_MTIMECMP 16'h4000
`define TILE_CLINT_MTIME 16'hbff8

`endif

//--- hw/tile_io_pkg.sv
`default_nettype none

package tile_io_pkg;

  // Memory command opcode
  typedef enum logic
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_opcode_e;

  // Router destinations and arbiter sources
  typedef enum logic [1:0]
  {
    e_dev_mem      = 2'd0,
    e_dev_cfg      = 2'd1,
    e_dev_clint    = 2'd2,
    e_dev_loopback = 2'd3
  } tile_dev_e;

endpackage

`default_nettype wire

//--- hw/tile_cmd_router.sv
`timescale 1ns/100ps
`default_nettype none

`include "tile_io_defines.svh"

module tile_cmd_router
  (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     cmd_v_i,
    input  tile_io_pkg::mem_opcode_e cmd_opcode_i,
    input  logic [`TILE_ADDR_W-1:0]  cmd_addr_i,
    input  logic [`TILE_DATA_W-1:0]  cmd_data_i,
    output logic                     cmd_ready_o,
    output logic [3:0]               dev_v_o,
    input  logic [3:0]               dev_ready_i,
    output tile_io_pkg::mem_opcode_e dev_opcode_o,
    output logic [`TILE_ADDR_W-1:0]  dev_addr_o,
    output logic [`TILE_DATA_W-1:0]  dev_data_o
  );

  import tile_io_pkg::*;

  logic [`TILE_DEV_W-1:0] dev_field;
  tile_dev_e              dst_d;
  tile_dev_e              dst_q;
  logic                   full_q;
  logic                   drain;
  logic                   accept;

  assign dev_field = cmd_addr_i[`TILE_DEV_LSB +: `TILE_DEV_W];

  // DRAM and the cache device both leave the tile
  always_comb
  begin
    if ((cmd_addr_i >= `TILE_DRAM_BASE) || (dev_field == `TILE_DEV_CACHE))
      dst_d = e_dev_mem;
    else if (dev_field == `TILE_DEV_CLINT)
      dst_d = e_dev_clint;
    else if (dev_field == `TILE_DEV_CFG)
      dst_d = e_dev_cfg;
    else
      dst_d = e_dev_loopback;
  end

  assign drain       = full_q & dev_ready_i[dst_q];
  assign cmd_ready_o = ~full_q | drain;
  assign accept      = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      full_q <= 1'b0;
      dst_q  <= e_dev_mem;
    end
    else if (accept)
    begin
      full_q <= 1'b1;
      dst_q  <= dst_d;
    end
    else if (drain)
      full_q <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      dev_opcode_o <= cmd_opcode_i;
      dev_addr_o   <= cmd_addr_i;
      dev_data_o   <= cmd_data_i;
    end
  end

  // Only the selected destination sees valid
  always_comb
  begin
    dev_v_o        = '0;
    dev_v_o[dst_q] = full_q;
  end

endmodule

`default_nettype wire

//--- hw/tile_cfg_slice.sv
`timescale 1ns/100ps
`default_nettype none

`include "tile_io_defines.svh"

module tile_cfg_slice
  (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     cmd_v_i,
    input  tile_io_pkg::mem_opcode_e cmd_opcode_i,
    input  logic [`TILE_ADDR_W-1:0]  cmd_addr_i,
    input  logic [`TILE_DATA_W-1:0]  cmd_data_i,
    output logic                     cmd_ready_o,
    output logic                     resp_v_o,
    output tile_io_pkg::mem_opcode_e resp_opcode_o,
    output logic [`TILE_ADDR_W-1:0]  resp_addr_o,
    output logic [`TILE_DATA_W-1:0]  resp_data_o,
    input  logic                     resp_ready_i,
    input  logic [`TILE_DID_W-1:0]   did_i,
    input  logic [`TILE_DID_W-1:0]   host_did_i,
    output logic                     freeze_o
  );

  import tile_io_pkg::*;

  logic [`TILE_OFS_W-1:0]  ofs;
  logic [`TILE_DATA_W-1:0] rd_data;
  logic                    accept;
  logic                    freeze_q;

  assign ofs         = cmd_addr_i[`TILE_OFS_W-1:0];
  assign cmd_ready_o = ~resp_v_o | resp_ready_i;
  assign accept      = cmd_v_i & cmd_ready_o;
  assign freeze_o    = freeze_q;

  always_comb
  begin
    case (ofs)
      `TILE_CFG_FREEZE:   rd_data = {{(`TILE_DATA_W-1){1'b0}}, freeze_q};
      `TILE_CFG_DID:      rd_data = {{(`TILE_DATA_W-`TILE_DID_W){1'b0}}, did_i};
      `TILE_CFG_HOST_DID: rd_data = {{(`TILE_DATA_W-`TILE_DID_W){1'b0}}, host_did_i};
      default:            rd_data = '0;
    endcase
  end

  // Tile comes out of reset frozen
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_o <= 1'b0;
      freeze_q <= 1'b1;
    end
    else
    begin
      if (accept)
        resp_v_o <= 1'b1;
      else if (resp_ready_i)
        resp_v_o <= 1'b0;
      if (accept && (cmd_opcode_i == e_mem_wr) && (ofs == `TILE_CFG_FREEZE))
        freeze_q <= cmd_data_i[0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_opcode_o <= cmd_opcode_i;
      resp_addr_o   <= cmd_addr_i;
      resp_data_o   <= (cmd_opcode_i == e_mem_rd) ? rd_data : '0;
    end
  end

endmodule

`default_nettype wire

//--- hw/tile_clint_slice.sv
`timescale 1ns/100ps
`default_nettype none

`include "tile_io_defines.svh"

module tile_clint_slice
  (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     cmd_v_i,
    input  tile_io_pkg::mem_opcode_e cmd_opcode_i,
    input  logic [`TILE_ADDR_W-1:0]  cmd_addr_i,
    input  logic [`TILE_DATA_W-1:0]  cmd_data_i,
    output logic                     cmd_ready_o,
    output logic                     resp_v_o,
    output tile_io_pkg::mem_opcode_e resp_opcode_o,
    output logic [`TILE_ADDR_W-1:0]  resp_addr_o,
    output logic [`TILE_DATA_W-1:0]  resp_data_o,
    input  logic                     resp_ready_i,
    output logic                     timer_irq_o,
    output logic                     software_irq_o
  );

  import tile_io_pkg::*;

  logic [`TILE_OFS_W-1:0]  ofs;
  logic [`TILE_DATA_W-1:0] rd_data;
  logic [`TILE_DATA_W-1:0] mtime_q;
  logic [`TILE_DATA_W-1:0] mtimecmp_q;
  logic                    msip_q;
  logic                    accept;
  logic                    wr;

  assign ofs            = cmd_addr_i[`TILE_OFS_W-1:0];
  assign cmd_ready_o    = ~resp_v_o | resp_ready_i;
  assign accept         = cmd_v_i & cmd_ready_o;
  assign wr             = accept & (cmd_opcode_i == e_mem_wr);
  assign software_irq_o = msip_q;

  always_comb
  begin
    case (ofs)
      `TILE_CLINT_MSIP:     rd_data = {{(`TILE_DATA_W-1){1'b0}}, msip_q};
      `TILE_CLINT_MTIMECMP: rd_data = mtimecmp_q;
      `TILE_CLINT_MTIME:    rd_data = mtime_q;
      default:              rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_o    <= 1'b0;
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_o <= 1'b0;
    end
    else
    begin
      if (accept)
        resp_v_o <= 1'b1;
      else if (resp_ready_i)
        resp_v_o <= 1'b0;

      // A write replaces this cycle's increment
      if (wr && (ofs == `TILE_CLINT_MTIME))
        mtime_q <= cmd_data_i;
      else
        mtime_q <= mtime_q + 1'b1;

      if (wr && (ofs == `TILE_CLINT_MTIMECMP))
        mtimecmp_q <= cmd_data_i;
      if (wr && (ofs == `TILE_CLINT_MSIP))
        msip_q <= cmd_data_i[0];

      timer_irq_o <= (mtime_q >= mtimecmp_q);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_opcode_o <= cmd_opcode_i;
      resp_addr_o   <= cmd_addr_i;
      resp_data_o   <= (cmd_opcode_i == e_mem_rd) ? rd_data : '0;
    end
  end

endmodule

`default_nettype wire

//--- hw/tile_loopback.sv
`timescale 1ns/100ps
`default_nettype none

`include "tile_io_defines.svh"

module tile_loopback
  (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     cmd_v_i,
    input  tile_io_pkg::mem_opcode_e cmd_opcode_i,
    input  logic [`TILE_ADDR_W-1:0]  cmd_addr_i,
    output logic                     cmd_ready_o,
    output logic                     resp_v_o,
    output tile_io_pkg::mem_opcode_e resp_opcode_o,
    output logic [`TILE_ADDR_W-1:0]  resp_addr_o,
    output logic [`TILE_DATA_W-1:0]  resp_data_o,
    input  logic                     resp_ready_i
  );

  import tile_io_pkg::*;

  mem_opcode_e opcode_q;
  logic        accept;

  assign cmd_ready_o   = ~resp_v_o | resp_ready_i;
  assign accept        = cmd_v_i & cmd_ready_o;
  assign resp_opcode_o = opcode_q;
  // No storage behind unmapped devices
  assign resp_data_o   = '0;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      resp_v_o <= 1'b0;
    else if (accept)
      resp_v_o <= 1'b1;
    else if (resp_ready_i)
      resp_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      opcode_q    <= cmd_opcode_i;
      resp_addr_o <= cmd_addr_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/tile_resp_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "tile_io_defines.svh"

module tile_resp_arbiter
  (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic [3:0]                          src_v_i,
    input  tile_io_pkg::mem_opcode_e [3:0]      src_opcode_i,
    input  logic [3:0][`TILE_ADDR_W-1:0]        src_addr_i,
    input  logic [3:0][`TILE_DATA_W-1:0]        src_data_i,
    output logic [3:0]                          src_ready_o,
    output logic                                resp_v_o,
    output tile_io_pkg::mem_opcode_e            resp_opcode_o,
    output logic [`TILE_ADDR_W-1:0]             resp_addr_o,
    output logic [`TILE_DATA_W-1:0]             resp_data_o,
    input  logic                                resp_ready_i
  );

  import tile_io_pkg::*;

  tile_dev_e ptr_q;
  tile_dev_e grant;
  logic      grant_v;
  logic      load;

  assign load = ~resp_v_o | resp_ready_i;

  // Nearest valid source at or after the pointer wins
  always_comb
  begin
    tile_dev_e idx;
    grant   = ptr_q;
    grant_v = 1'b0;
    for (int i = 3; i >= 0; i--)
    begin
      idx = tile_dev_e'(ptr_q + 2'(i));
      if (src_v_i[idx])
      begin
        grant   = idx;
        grant_v = 1'b1;
      end
    end
  end

  always_comb
  begin
    src_ready_o        = '0;
    src_ready_o[grant] = grant_v & load;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_o <= 1'b0;
      ptr_q    <= e_dev_mem;
    end
    else if (load)
    begin
      resp_v_o <= grant_v;
      if (grant_v)
        ptr_q <= tile_dev_e'(grant + 2'd1);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (load && grant_v)
    begin
      resp_opcode_o <= src_opcode_i[grant];
      resp_addr_o   <= src_addr_i[grant];
      resp_data_o   <= src_data_i[grant];
    end
  end

endmodule

`default_nettype wire

//--- hw/tile_io_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "tile_io_defines.svh"

module tile_io_top
  (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic [`TILE_DID_W-1:0]   did_i,
    input  logic [`TILE_DID_W-1:0]   host_did_i,
    input  logic                     cmd_v_i,
    input  tile_io_pkg::mem_opcode_e cmd_opcode_i,
    input  logic [`TILE_ADDR_W-1:0]  cmd_addr_i,
    input  logic [`TILE_DATA_W-1:0]  cmd_data_i,
    output logic                     cmd_ready_o,
    output logic                     resp_v_o,
    output tile_io_pkg::mem_opcode_e resp_opcode_o,
    output logic [`TILE_ADDR_W-1:0]  resp_addr_o,
    output logic [`TILE_DATA_W-1:0]  resp_data_o,
    input  logic                     resp_ready_i,
    output logic                     mem_cmd_v_o,
    output tile_io_pkg::mem_opcode_e mem_cmd_opcode_o,
    output logic [`TILE_ADDR_W-1:0]  mem_cmd_addr_o,
    output logic [`TILE_DATA_W-1:0]  mem_cmd_data_o,
    input  logic                     mem_cmd_ready_i,
    input  logic                     mem_resp_v_i,
    input  tile_io_pkg::mem_opcode_e mem_resp_opcode_i,
    input  logic [`TILE_ADDR_W-1:0]  mem_resp_addr_i,
    input  logic [`TILE_DATA_W-1:0]  mem_resp_data_i,
    output logic                     mem_resp_ready_o,
    output logic                     freeze_o,
    output logic                     timer_irq_o,
    output logic                     software_irq_o
  );

  import tile_io_pkg::*;

  // Router to devices
  logic [3:0]              dev_v;
  logic [3:0]              dev_ready;
  mem_opcode_e             dev_opcode;
  logic [`TILE_ADDR_W-1:0] dev_addr;
  logic [`TILE_DATA_W-1:0] dev_data;

  // Devices to arbiter
  logic [3:0]                   src_v;
  logic [3:0]                   src_ready;
  mem_opcode_e [3:0]            src_opcode;
  logic [3:0][`TILE_ADDR_W-1:0] src_addr;
  logic [3:0][`TILE_DATA_W-1:0] src_data;

  // External memory stands in for the cache slice
  assign mem_cmd_v_o              = dev_v[e_dev_mem];
  assign mem_cmd_opcode_o         = dev_opcode;
  assign mem_cmd_addr_o           = dev_addr;
  assign mem_cmd_data_o           = dev_data;
  assign dev_ready[e_dev_mem]     = mem_cmd_ready_i;
  assign src_v[e_dev_mem]         = mem_resp_v_i;
  assign src_opcode[e_dev_mem]    = mem_resp_opcode_i;
  assign src_addr[e_dev_mem]      = mem_resp_addr_i;
  assign src_data[e_dev_mem]      = mem_resp_data_i;
  assign mem_resp_ready_o         = src_ready[e_dev_mem];

  tile_cmd_router i_router
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_opcode_i (cmd_opcode_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_data_i   (cmd_data_i),
    .cmd_ready_o  (cmd_ready_o),
    .dev_v_o      (dev_v),
    .dev_ready_i  (dev_ready),
    .dev_opcode_o (dev_opcode),
    .dev_addr_o   (dev_addr),
    .dev_data_o   (dev_data)
  );

  tile_cfg_slice i_cfg
  (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cmd_v_i       (dev_v[e_dev_cfg]),
    .cmd_opcode_i  (dev_opcode),
    .cmd_addr_i    (dev_addr),
    .cmd_data_i    (dev_data),
    .cmd_ready_o   (dev_ready[e_dev_cfg]),
    .resp_v_o      (src_v[e_dev_cfg]),
    .resp_opcode_o (src_opcode[e_dev_cfg]),
    .resp_addr_o   (src_addr[e_dev_cfg]),
    .resp_data_o   (src_data[e_dev_cfg]),
    .resp_ready_i  (src_ready[e_dev_cfg]),
    .did_i         (did_i),
    .host_did_i    (host_did_i),
    .freeze_o      (freeze_o)
  );

  tile_clint_slice i_clint
  (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cmd_v_i        (dev_v[e_dev_clint]),
    .cmd_opcode_i   (dev_opcode),
    .cmd_addr_i     (dev_addr),
    .cmd_data_i     (dev_data),
    .cmd_ready_o    (dev_ready[e_dev_clint]),
    .resp_v_o       (src_v[e_dev_clint]),
    .resp_opcode_o  (src_opcode[e_dev_clint]),
    .resp_addr_o    (src_addr[e_dev_clint]),
    .resp_data_o    (src_data[e_dev_clint]),
    .resp_ready_i   (src_ready[e_dev_clint]),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o)
  );

  tile_loopback i_loopback
  (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cmd_v_i       (dev_v[e_dev_loopback]),
    .cmd_opcode_i  (dev_opcode),
    .cmd_addr_i    (dev_addr),
    .cmd_ready_o   (dev_ready[e_dev_loopback]),
    .resp_v_o      (src_v[e_dev_loopback]),
    .resp_opcode_o (src_opcode[e_dev_loopback]),
    .resp_addr_o   (src_addr[e_dev_loopback]),
    .resp_data_o   (src_data[e_dev_loopback]),
    .resp_ready_i  (src_ready[e_dev_loopback])
  );

  tile_resp_arbiter i_arbiter
  (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .src_v_i       (src_v),
    .src_opcode_i  (src_opcode),
    .src_addr_i    (src_addr),
    .src_data_i    (src_data),
    .src_ready_o   (src_ready),
    .resp_v_o      (resp_v_o),
    .resp_opcode_o (resp_opcode_o),
    .resp_addr_o   (resp_addr_o),
    .resp_data_o   (resp_data_o),
    .resp_ready_i  (resp_ready_i)
  );

endmodule

`default_nettype wire

//--- tests/tile_io_chk.sv
`timescale 1ns/100ps
`default_nettype none

`include "tile_io_defines.svh"

module tile_io_chk
  (
    input logic                     clk_i,
    input logic                     rst_n_i,
    input logic                     resp_v_i,
    input logic                     resp_ready_i,
    input tile_io_pkg::mem_opcode_e resp_opcode_i,
    input logic [`TILE_ADDR_W-1:0]  resp_addr_i,
    input logic [`TILE_DATA_W-1:0]  resp_data_i,
    input logic                     mem_cmd_v_i,
    input logic                     mem_cmd_ready_i,
    input tile_io_pkg::mem_opcode_e mem_cmd_opcode_i,
    input logic [`TILE_ADDR_W-1:0]  mem_cmd_addr_i,
    input logic [`TILE_DATA_W-1:0]  mem_cmd_data_i,
    input logic                     freeze_i
  );

  // A stalled message must not move
  resp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_v_i && !resp_ready_i |=>
      resp_v_i && $stable(resp_opcode_i) && $stable(resp_addr_i) && $stable(resp_data_i))
    else $error("resp stream changed while stalled");

  mem_cmd_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_cmd_v_i && !mem_cmd_ready_i |=>
      mem_cmd_v_i && $stable(mem_cmd_opcode_i) && $stable(mem_cmd_addr_i)
      && $stable(mem_cmd_data_i))
    else $error("mem_cmd stream changed while stalled");

  resp_idle_in_reset: assert property (@(posedge clk_i)
    !rst_n_i && $past(!rst_n_i) |-> !resp_v_i)
    else $error("resp_v_o high during reset");

  // Tile leaves reset frozen
  freeze_after_reset: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> freeze_i)
    else $error("freeze_o low in first cycle after reset");

endmodule

`default_nettype wire

//--- tests/tile_io_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "tile_io_defines.svh"

module tile_io_tb;

  import tile_io_pkg::*;

  localparam int TIMEOUT = 200;
  localparam int N_MAX   = 32;

  // Follow-up check run after a response
  localparam int SIDE_NONE   = 0;
  localparam int SIDE_MEM    = 1;
  localparam int SIDE_FREEZE = 2;
  localparam int SIDE_SWIRQ  = 3;
  localparam int SIDE_MTIME  = 4;
  localparam int SIDE_TIRQ_H = 5;
  localparam int SIDE_TIRQ_L = 6;

  logic                    clk_i;
  logic                    rst_n_i;
  logic [`TILE_DID_W-1:0]  did_i;
  logic [`TILE_DID_W-1:0]  host_did_i;
  logic                    cmd_v_i;
  mem_opcode_e             cmd_opcode_i;
  logic [`TILE_ADDR_W-1:0] cmd_addr_i;
  logic [`TILE_DATA_W-1:0] cmd_data_i;
  logic                    cmd_ready_o;
  logic                    resp_v_o;
  mem_opcode_e             resp_opcode_o;
  logic [`TILE_ADDR_W-1:0] resp_addr_o;
  logic [`TILE_DATA_W-1:0] resp_data_o;
  logic                    resp_ready_i;
  logic                    mem_cmd_v_o;
  mem_opcode_e             mem_cmd_opcode_o;
  logic [`TILE_ADDR_W-1:0] mem_cmd_addr_o;
  logic [`TILE_DATA_W-1:0] mem_cmd_data_o;
  logic                    mem_cmd_ready_i;
  logic                    mem_resp_v_i;
  mem_opcode_e             mem_resp_opcode_i;
  logic [`TILE_ADDR_W-1:0] mem_resp_addr_i;
  logic [`TILE_DATA_W-1:0] mem_resp_data_i;
  logic                    mem_resp_ready_o;
  logic                    freeze_o;
  logic                    timer_irq_o;
  logic                    software_irq_o;

  // Stimulus table
  mem_opcode_e             tbl_op    [N_MAX];
  logic [`TILE_ADDR_W-1:0] tbl_addr  [N_MAX];
  logic [`TILE_DATA_W-1:0] tbl_wdata [N_MAX];
  logic [`TILE_DATA_W-1:0] tbl_exp   [N_MAX];
  int                      tbl_stall [N_MAX];
  int                      tbl_side  [N_MAX];
  string                   tbl_name  [N_MAX];
  int                      n_tbl;

  logic [`TILE_DATA_W-1:0] mem_model [logic [`TILE_ADDR_W-1:0]];
  mem_opcode_e             hdr_op;
  logic [`TILE_ADDR_W-1:0] hdr_addr;
  logic [`TILE_DATA_W-1:0] hdr_data;
  int                      mem_seen;
  mem_opcode_e             got_op;
  logic [`TILE_ADDR_W-1:0] got_addr;
  logic [`TILE_DATA_W-1:0] got_data;
  logic [`TILE_DATA_W-1:0] last_mtime;
  bit                      have_mtime;
  bit                      hung;
  int                      errors;
  int                      tests_run;
  int                      tests_failed;
  int                      seed = 32'h1b0c;

  tile_io_top i_tile_io_top
  (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .did_i             (did_i),
    .host_did_i        (host_did_i),
    .cmd_v_i           (cmd_v_i),
    .cmd_opcode_i      (cmd_opcode_i),
    .cmd_addr_i        (cmd_addr_i),
    .cmd_data_i        (cmd_data_i),
    .cmd_ready_o       (cmd_ready_o),
    .resp_v_o          (resp_v_o),
    .resp_opcode_o     (resp_opcode_o),
    .resp_addr_o       (resp_addr_o),
    .resp_data_o       (resp_data_o),
    .resp_ready_i      (resp_ready_i),
    .mem_cmd_v_o       (mem_cmd_v_o),
    .mem_cmd_opcode_o  (mem_cmd_opcode_o),
    .mem_cmd_addr_o    (mem_cmd_addr_o),
    .mem_cmd_data_o    (mem_cmd_data_o),
    .mem_cmd_ready_i   (mem_cmd_ready_i),
    .mem_resp_v_i      (mem_resp_v_i),
    .mem_resp_opcode_i (mem_resp_opcode_i),
    .mem_resp_addr_i   (mem_resp_addr_i),
    .mem_resp_data_i   (mem_resp_data_i),
    .mem_resp_ready_o  (mem_resp_ready_o),
    .freeze_o          (freeze_o),
    .timer_irq_o       (timer_irq_o),
    .software_irq_o    (software_irq_o)
  );

  bind tile_io_top tile_io_chk i_chk
  (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .resp_v_i         (resp_v_o),
    .resp_ready_i     (resp_ready_i),
    .resp_opcode_i    (resp_opcode_o),
    .resp_addr_i      (resp_addr_o),
    .resp_data_i      (resp_data_o),
    .mem_cmd_v_i      (mem_cmd_v_o),
    .mem_cmd_ready_i  (mem_cmd_ready_i),
    .mem_cmd_opcode_i (mem_cmd_opcode_o),
    .mem_cmd_addr_i   (mem_cmd_addr_o),
    .mem_cmd_data_i   (mem_cmd_data_o),
    .freeze_i         (freeze_o)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [`TILE_ADDR_W-1:0] local_addr(input logic [3:0] dev,
                                                         input logic [15:0] ofs);
    return (32'(dev) << `TILE_DEV_LSB) | 32'(ofs);
  endfunction

  // Unwritten memory reads back a pattern of its address
  function automatic logic [`TILE_DATA_W-1:0] mem_fill(input logic [`TILE_ADDR_W-1:0] addr);
    return {addr ^ 32'h5a5a_c3c3, ~addr};
  endfunction

  task automatic report_err(input string sig, input logic [63:0] got, input logic [63:0] exp);
    $display("[ERROR] %0t %s: got %h, expected %h", $time, sig, got, exp);
    errors++;
  endtask

  task automatic add_entry(input string name, input mem_opcode_e op,
                           input logic [31:0] addr, input logic [63:0] wdata,
                           input logic [63:0] exp, input int stall, input int side);
    tbl_name[n_tbl]  = name;
    tbl_op[n_tbl]    = op;
    tbl_addr[n_tbl]  = addr;
    tbl_wdata[n_tbl] = wdata;
    tbl_exp[n_tbl]   = exp;
    tbl_stall[n_tbl] = stall;
    tbl_side[n_tbl]  = side;
    n_tbl++;
  endtask

  task automatic build_table();
    logic [31:0] cfg;
    logic [31:0] clint;
    cfg   = local_addr(`TILE_DEV_CFG, 16'h0);
    clint = local_addr(`TILE_DEV_CLINT, 16'h0);
    n_tbl = 0;
    add_entry("freeze rd", e_mem_rd, cfg | `TILE_CFG_FREEZE, 0, 64'd1, 0, SIDE_NONE);
    add_entry("freeze clr", e_mem_wr, cfg | `TILE_CFG_FREEZE, 0, 0, 2, SIDE_FREEZE);
    add_entry("freeze rd0", e_mem_rd, cfg | `TILE_CFG_FREEZE, 0, 0, 0, SIDE_NONE);
    add_entry("did rd", e_mem_rd, cfg | `TILE_CFG_DID, 0, 64'h3c, 1, SIDE_NONE);
    add_entry("host did rd", e_mem_rd, cfg | `TILE_CFG_HOST_DID, 0, 64'ha5, 0, SIDE_NONE);
    add_entry("cfg unknown rd", e_mem_rd, cfg | 32'h18, 0, 0, 3, SIDE_NONE);
    add_entry("cfg unknown wr", e_mem_wr, cfg | 32'h20, 64'h77, 0, 1, SIDE_NONE);
    add_entry("cfg unknown rd2", e_mem_rd, cfg | 32'h20, 0, 0, 0, SIDE_NONE);
    add_entry("dram wr", e_mem_wr, 32'h8000_0040, 64'h0123_4567_89ab_cdef, 0, 0, SIDE_MEM);
    add_entry("dram rd", e_mem_rd, 32'h8000_0040, 0, 64'h0123_4567_89ab_cdef, 2, SIDE_MEM);
    add_entry("cache wr", e_mem_wr, 32'h0030_0100, 64'hfeed_face_0bad_f00d, 0, 1, SIDE_MEM);
    add_entry("cache rd", e_mem_rd, 32'h0030_0100, 0, 64'hfeed_face_0bad_f00d, 4, SIDE_MEM);
    add_entry("dram cold rd", e_mem_rd, 32'hc000_1000, 0, mem_fill(32'hc000_1000), 1, SIDE_MEM);
    add_entry("msip wr", e_mem_wr, clint | `TILE_CLINT_MSIP, 64'd1, 0, 0, SIDE_SWIRQ);
    add_entry("msip rd", e_mem_rd, clint | `TILE_CLINT_MSIP, 0, 64'd1, 1, SIDE_NONE);
    add_entry("mtime rd", e_mem_rd, clint | `TILE_CLINT_MTIME, 0, 0, 0, SIDE_MTIME);
    add_entry("mtime rd2", e_mem_rd, clint | `TILE_CLINT_MTIME, 0, 0, 2, SIDE_MTIME);
    add_entry("mtimecmp low", e_mem_wr, clint | `TILE_CLINT_MTIMECMP, 64'h40, 0, 0, SIDE_TIRQ_H);
    add_entry("mtimecmp rd", e_mem_rd, clint | `TILE_CLINT_MTIMECMP, 0, 64'h40, 1, SIDE_NONE);
    add_entry("mtimecmp max", e_mem_wr, clint | `TILE_CLINT_MTIMECMP, '1, 0, 0, SIDE_TIRQ_L);
    add_entry("loopback rd", e_mem_rd, local_addr(4'd5, 16'h0020), 0, 0, 0, SIDE_NONE);
    add_entry("loopback wr", e_mem_wr, local_addr(4'hf, 16'h0008), 64'h55, 0, 5, SIDE_NONE);
  endtask

  task automatic send_cmd(input int idx);
    int cnt;
    cmd_v_i      = 1'b1;
    cmd_opcode_i = tbl_op[idx];
    cmd_addr_i   = tbl_addr[idx];
    cmd_data_i   = tbl_wdata[idx];
    cnt          = 0;
    @(negedge clk_i);
    while (!cmd_ready_o && cnt < TIMEOUT)
    begin
      @(negedge clk_i);
      cnt++;
    end
    if (!cmd_ready_o)
    begin
      $display("Command %0d was never accepted by %0t", idx, $time);
      errors++;
      hung = 1'b1;
    end
    @(posedge clk_i);
    #1;
    cmd_v_i = 1'b0;
  endtask

  task automatic recv_resp(input int idx);
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    while (!resp_v_o && cnt < TIMEOUT)
    begin
      @(negedge clk_i);
      cnt++;
    end
    if (!resp_v_o)
    begin
      $display("No response for command %0d by %0t", idx, $time);
      errors++;
      hung = 1'b1;
    end
    else
    begin
      // Keep the response stalled for a while
      repeat (tbl_stall[idx]) @(negedge clk_i);
      @(posedge clk_i);
      #1;
      resp_ready_i = 1'b1;
      @(negedge clk_i);
      got_op   = resp_opcode_o;
      got_addr = resp_addr_o;
      got_data = resp_data_o;
      if (!resp_v_o)
      begin
        $display("Response %0d was dropped while stalled, at %0t", idx, $time);
        errors++;
      end
      @(posedge clk_i);
      #1;
      resp_ready_i = 1'b0;
    end
  endtask

  task automatic wait_timer_irq(input logic level);
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    while (timer_irq_o !== level && cnt < TIMEOUT)
    begin
      @(negedge clk_i);
      cnt++;
    end
    if (timer_irq_o !== level)
    begin
      $display("timer_irq_o did not go to %0b within %0d cycles", level, TIMEOUT);
      errors++;
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_resp(input int idx, input int seen_before);
    if (got_op !== tbl_op[idx])
      report_err("resp_opcode_o", 64'(got_op), 64'(tbl_op[idx]));
    if (got_addr !== tbl_addr[idx])
      report_err("resp_addr_o", 64'(got_addr), 64'(tbl_addr[idx]));
    if (tbl_side[idx] != SIDE_MTIME && got_data !== tbl_exp[idx])
      report_err("resp_data_o", got_data, tbl_exp[idx]);
    case (tbl_side[idx])
      SIDE_MEM:
      begin
        if (mem_seen == seen_before)
        begin
          $display("Command %0d never appeared on mem_cmd", idx);
          errors++;
        end
        else
        begin
          if (hdr_op !== tbl_op[idx])
            report_err("mem_cmd_opcode_o", 64'(hdr_op), 64'(tbl_op[idx]));
          if (hdr_addr !== tbl_addr[idx])
            report_err("mem_cmd_addr_o", 64'(hdr_addr), 64'(tbl_addr[idx]));
          if (tbl_op[idx] == e_mem_wr && hdr_data !== tbl_wdata[idx])
            report_err("mem_cmd_data_o", hdr_data, tbl_wdata[idx]);
        end
      end
      SIDE_FREEZE:
        if (freeze_o !== 1'b0)
          report_err("freeze_o", 64'(freeze_o), 64'd0);
      SIDE_SWIRQ:
        if (software_irq_o !== 1'b1)
          report_err("software_irq_o", 64'(software_irq_o), 64'd1);
      SIDE_MTIME:
      begin
        if (have_mtime && got_data <= last_mtime)
        begin
          $display("[ERROR] %0t resp_data_o: got %h, expected above %h",
                   $time, got_data, last_mtime);
          errors++;
        end
        have_mtime = 1'b1;
        last_mtime = got_data;
      end
      SIDE_TIRQ_H: wait_timer_irq(1'b1);
      SIDE_TIRQ_L: wait_timer_irq(1'b0);
      default: ;
    endcase
  endtask

  task automatic check_reset_state();
    @(negedge clk_i);
    if (cmd_ready_o !== 1'b1)
      report_err("cmd_ready_o", 64'(cmd_ready_o), 64'd1);
    if (resp_v_o !== 1'b0)
      report_err("resp_v_o", 64'(resp_v_o), 64'd0);
    if (mem_cmd_v_o !== 1'b0)
      report_err("mem_cmd_v_o", 64'(mem_cmd_v_o), 64'd0);
    if (timer_irq_o !== 1'b0)
      report_err("timer_irq_o", 64'(timer_irq_o), 64'd0);
    if (software_irq_o !== 1'b0)
      report_err("software_irq_o", 64'(software_irq_o), 64'd0);
    if (freeze_o !== 1'b1)
      report_err("freeze_o", 64'(freeze_o), 64'd1);
    @(posedge clk_i);
    #1;
  endtask

  // External memory answers after a random delay
  task automatic serve_mem();
    logic [`TILE_DATA_W-1:0] rdata;
    int                      cnt;
    hdr_op   = mem_cmd_opcode_o;
    hdr_addr = mem_cmd_addr_o;
    hdr_data = mem_cmd_data_o;
    mem_seen++;
    @(posedge clk_i);
    #1;
    repeat ($unsigned($random(seed)) % 4)
    begin
      @(posedge clk_i);
      #1;
    end
    mem_cmd_ready_i = 1'b1;
    @(posedge clk_i);
    #1;
    mem_cmd_ready_i = 1'b0;
    if (hdr_op == e_mem_wr)
    begin
      mem_model[hdr_addr] = hdr_data;
      rdata = '0;
    end
    else if (mem_model.exists(hdr_addr))
      rdata = mem_model[hdr_addr];
    else
      rdata = mem_fill(hdr_addr);
    repeat ($unsigned($random(seed)) % 4)
    begin
      @(posedge clk_i);
      #1;
    end
    mem_resp_v_i      = 1'b1;
    mem_resp_opcode_i = hdr_op;
    mem_resp_addr_i   = hdr_addr;
    mem_resp_data_i   = rdata;
    cnt = 0;
    @(negedge clk_i);
    while (!mem_resp_ready_o && cnt < TIMEOUT)
    begin
      @(negedge clk_i);
      cnt++;
    end
    if (!mem_resp_ready_o)
    begin
      $display("Memory response was never accepted by %0t", $time);
      errors++;
      hung = 1'b1;
    end
    @(posedge clk_i);
    #1;
    mem_resp_v_i = 1'b0;
  endtask

  initial
  begin
    mem_cmd_ready_i   = 1'b0;
    mem_resp_v_i      = 1'b0;
    mem_resp_opcode_i = e_mem_rd;
    mem_resp_addr_i   = '0;
    mem_resp_data_i   = '0;
    mem_seen          = 0;
    forever
    begin
      @(negedge clk_i);
      if (rst_n_i && mem_cmd_v_o)
        serve_mem();
    end
  end

  initial
  begin
    int err_before;
    int seen_before;
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    did_i        = 8'h3c;
    host_did_i   = 8'ha5;
    cmd_v_i      = 1'b0;
    cmd_opcode_i = e_mem_rd;
    cmd_addr_i   = '0;
    cmd_data_i   = '0;
    resp_ready_i = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    have_mtime   = 1'b0;
    hung         = 1'b0;
    build_table();
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check_reset_state();
    for (int i = 0; i < n_tbl; i++)
    begin
      err_before  = errors;
      seen_before = mem_seen;
      send_cmd(i);
      if (!hung)
        recv_resp(i);
      if (!hung)
        check_resp(i, seen_before);
      tests_run++;
      if (errors != err_before)
        tests_failed++;
      $display("test %0d %s: %s", i, tbl_name[i], (errors == err_before) ? "ok" : "mismatch");
      if (hung)
        break;
    end
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hw
hw/tile_io_pkg.sv
hw/tile_cmd_router.sv
hw/tile_cfg_slice.sv
hw/tile_clint_slice.sv
hw/tile_loopback.sv
hw/tile_resp_arbiter.sv
hw/tile_io_top.sv
tests/tile_io_chk.sv
tests/tile_io_tb.sv

//--- Makefile
# Verilator build and run for the tile device network

VERILATOR ?= verilator
TOP       ?= tile_io_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The status comes from the search for the pass line
run: compile
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)
